// ==== gaussian_blur.f ====
+incdir+src
src/blur_geom_pkg.sv
src/blur_ctrl_pkg.sv
src/strip_scan_ctrl.sv
src/strip_window.sv
src/blur_lane.sv
src/strip_merge.sv
src/gaussian_blur_top.sv
testbench/tb_clock.sv
testbench/blur_checker.sv
testbench/tb_gaussian_blur.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_gaussian_blur
FILELIST  ?= gaussian_blur.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_gaussian_blur.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blur_macros.svh"

module tb_gaussian_blur;

  localparam int ROW_PIXELS = blur_geom_pkg::ROW_PIXELS;
  localparam int MEM_DEPTH = 1 << $bits(blur_geom_pkg::row_addr_t);
  localparam int NUM_TESTS = 7;
  localparam int RUN_CYCLES = `STRIPS * blur_ctrl_pkg::STRIP_PERIOD;
  localparam int TIMEOUT_CYCLES = 2 * NUM_TESTS * (RUN_CYCLES + 20);
  localparam int ALL_WRITES = `IMG_ROWS * `STRIPS;
  localparam int PAT_RANDOM = 0;
  localparam int PAT_CONST = 1;
  localparam int PAT_ZERO = 2;
  localparam int PAT_DOT = 3;
  // bright dot on the first pixel of strip 1
  localparam int DOT_ROW = 3;
  localparam int DOT_COL = `STRIP_PIXELS;

  // columns: name, pattern, value, probe row, probe col, probe pixel (-1 none), writes
  string test_name [NUM_TESTS] = '{"random_a", "const_mid", "const_edge", "const_corner",
                                   "all_zero", "dot_boundary", "random_b"};
  int test_pat [NUM_TESTS] = '{PAT_RANDOM, PAT_CONST, PAT_CONST, PAT_CONST,
                               PAT_ZERO, PAT_DOT, PAT_RANDOM};
  int test_val [NUM_TESTS] = '{0, 160, 160, 160, 0, 255, 0};
  int probe_row [NUM_TESTS] = '{0, 3, 7, 0, 4, 3, 0};
  int probe_col [NUM_TESTS] = '{0, 7, 5, 15, 9, 3, 0};
  int probe_exp [NUM_TESTS] = '{-1, 160, 120, 90, 0, 31, -1};
  int exp_writes [NUM_TESTS] = '{ALL_WRITES, ALL_WRITES, ALL_WRITES, ALL_WRITES,
                                 ALL_WRITES, ALL_WRITES, ALL_WRITES};

  logic                                       clk;
  logic                                       rst_n;
  logic                                       start;
  logic                                       done;
  logic                                       blur_we;
  blur_geom_pkg::row_addr_t                   img_addr;
  blur_geom_pkg::row_addr_t                   blur_addr_r;
  blur_geom_pkg::row_addr_t                   blur_addr_w;
  blur_geom_pkg::row_word_t                   img_dout = '0;
  blur_geom_pkg::row_word_t                   blur_dout = '0;
  blur_geom_pkg::row_word_t                   blur_din;
  blur_geom_pkg::row_word_t [MEM_DEPTH-1:0]   img_mem = '0;
  blur_geom_pkg::row_word_t [MEM_DEPTH-1:0]   blur_mem;
  logic [31:0]                                rng_state = 32'd74029;
  int                                         cycle_count = 0;

  tb_clock clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  gaussian_blur_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .done        (done),
    .img_addr    (img_addr),
    .img_dout    (img_dout),
    .blur_addr_r (blur_addr_r),
    .blur_dout   (blur_dout),
    .blur_we     (blur_we),
    .blur_addr_w (blur_addr_w),
    .blur_din    (blur_din)
  );

  blur_checker #(.DEPTH(MEM_DEPTH)) chk (
    .clk         (clk),
    .done        (done),
    .blur_we     (blur_we),
    .blur_addr_w (blur_addr_w),
    .image       (img_mem),
    .blur_mem    (blur_mem)
  );

  // image memory, one-cycle read latency
  always @(posedge clk) begin
    img_dout <= img_mem[img_addr];
  end

  // blur memory starts out full of stale rows so the first run must overwrite them
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int a = 0; a < MEM_DEPTH; a++) begin
        blur_mem[a] <= {ROW_PIXELS{`PIXEL_W'(a * 29 + 7)}};
      end
    end else if (blur_we) begin
      blur_mem[blur_addr_w] <= blur_din;
    end
    blur_dout <= blur_mem[blur_addr_r];
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic load_image(input int pat, input int value);
    blur_geom_pkg::pixel_t pix;
    for (int r = 0; r < `IMG_ROWS; r++) begin
      for (int c = 0; c < ROW_PIXELS; c++) begin
        pix = '0;
        if (pat == PAT_RANDOM) begin
          rng_state = xorshift32(rng_state);
          pix = rng_state[15:8];
        end else if (pat == PAT_CONST) begin
          pix = `PIXEL_W'(value);
        end else if (pat == PAT_DOT && r == DOT_ROW && c == DOT_COL) begin
          pix = `PIXEL_W'(value);
        end
        img_mem[r][ROW_PIXELS-1-c] = pix;
      end
    end
  endtask

  initial begin
    start = 1'b0;
    @(posedge rst_n);
    @(negedge clk);
    for (int t = 0; t < NUM_TESTS; t++) begin
      load_image(test_pat[t], test_val[t]);
      chk.begin_test(test_name[t]);
      // low after reset, otherwise still high from the last run
      chk.check_done(t > 0, "before start");
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      chk.check_done(1'b0, "after start");
      // a second start in the middle of the scan
      repeat (10) @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      while (done !== 1'b1) begin
        @(negedge clk);
      end
      chk.finish_test(probe_row[t], probe_col[t], probe_exp[t], exp_writes[t]);
      // controller passes through its done state before idle
      @(negedge clk);
    end
    chk.print_counts();
    if (chk.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/blur_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blur_macros.svh"

module blur_checker #(
  parameter int DEPTH = 16
) (
  input wire logic                                  clk,
  input wire logic                                  done,
  input wire logic                                  blur_we,
  input wire blur_geom_pkg::row_addr_t              blur_addr_w,
  input wire blur_geom_pkg::row_word_t [DEPTH-1:0]  image,
  input wire blur_geom_pkg::row_word_t [DEPTH-1:0]  blur_mem
);

  localparam int ROW_PIXELS = blur_geom_pkg::ROW_PIXELS;

  string cur_name = "";
  int    write_count = 0;
  int    bad_addr_count = 0;
  int    writes_at_start = 0;
  int    bad_at_start = 0;
  int    test_errors = 0;
  int    pass_count = 0;
  int    fail_count = 0;

  // write port is registered, so sample it between edges
  always @(negedge clk) begin
    if (blur_we === 1'b1) begin
      write_count <= write_count + 1;
      if (int'(blur_addr_w) >= `IMG_ROWS) begin
        bad_addr_count <= bad_addr_count + 1;
      end
    end
  end

  // zero outside the image on all four sides
  function automatic int image_pixel(input int r, input int c);
    if (r < 0 || r >= `IMG_ROWS || c < 0 || c >= ROW_PIXELS) begin
      return 0;
    end
    return int'(image[r][ROW_PIXELS-1-c]);
  endfunction

  // kernel 1 2 1 / 2 4 2 / 1 2 1, then drop the low bits
  function automatic int model_pixel(input int r, input int c);
    int sum;
    sum = 0;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        // per axis: 2 on the centre line, 1 beside it
        sum += (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1) * image_pixel(r + dr, c + dc);
      end
    end
    return sum >> `KERNEL_SHIFT;
  endfunction

  function automatic int blur_pixel(input int r, input int c);
    return int'(blur_mem[r][ROW_PIXELS-1-c]);
  endfunction

  task automatic begin_test(input string name);
    cur_name = name;
    writes_at_start = write_count;
    bad_at_start = bad_addr_count;
    test_errors = 0;
  endtask

  task automatic note_failure(input string what);
    $display("test %s: %s", cur_name, what);
    test_errors++;
  endtask

  task automatic check_done(input logic exp_level, input string when_text);
    if (done !== exp_level) begin
      note_failure($sformatf("done was %b %s instead of %b", done, when_text, exp_level));
    end
  endtask

  task automatic finish_test(input int probe_r, input int probe_c, input int probe_exp,
                             input int exp_writes);
    int writes;
    int bad;
    int mis_r;
    int mis_c;
    int exp_pix;
    int act_pix;
    bit mismatch;
    writes = write_count - writes_at_start;
    bad = bad_addr_count - bad_at_start;
    mismatch = 1'b0;
    // probe value comes straight from the test table
    if (probe_exp >= 0 && blur_pixel(probe_r, probe_c) != probe_exp) begin
      mismatch = 1'b1;
      mis_r = probe_r;
      mis_c = probe_c;
      exp_pix = probe_exp;
      act_pix = blur_pixel(probe_r, probe_c);
    end
    for (int r = 0; r < `IMG_ROWS; r++) begin
      for (int c = 0; c < ROW_PIXELS; c++) begin
        if (!mismatch && blur_pixel(r, c) != model_pixel(r, c)) begin
          mismatch = 1'b1;
          mis_r = r;
          mis_c = c;
          exp_pix = model_pixel(r, c);
          act_pix = blur_pixel(r, c);
        end
      end
    end
    if (writes != exp_writes) begin
      note_failure($sformatf("the DUT made %0d writes instead of %0d", writes, exp_writes));
    end
    if (bad != 0) begin
      note_failure($sformatf("%0d writes went past the last image row", bad));
    end
    if (mismatch) begin
      $display("FAIL %s pixel (%0d,%0d) expected %0d actual %0d",
               cur_name, mis_r, mis_c, exp_pix, act_pix);
    end
    if (mismatch || test_errors != 0) begin
      fail_count++;
    end else begin
      pass_count++;
      $display("PASS %s", cur_name);
    end
  endtask

  task automatic print_counts();
    $display("tests passed %0d, failed %0d", pass_count, fail_count);
  endtask

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset held over two rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== src/gaussian_blur_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blur_macros.svh"

module gaussian_blur_top (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      start,
  output logic                           done,
  output blur_geom_pkg::row_addr_t       img_addr,
  input  wire blur_geom_pkg::row_word_t  img_dout,
  output blur_geom_pkg::row_addr_t       blur_addr_r,
  input  wire blur_geom_pkg::row_word_t  blur_dout,
  output logic                           blur_we,
  output blur_geom_pkg::row_addr_t       blur_addr_w,
  output blur_geom_pkg::row_word_t       blur_din
);

  logic                          row_valid;
  logic                          fill_zero;
  logic                          strip_start;
  blur_geom_pkg::strip_idx_t     strip_idx;
  logic                          win_valid;
  blur_geom_pkg::window_t        windows [`STRIP_PIXELS];
  logic [`STRIP_PIXELS-1:0]      lane_valid;
  blur_geom_pkg::strip_pixels_t  lane_pixels;

  strip_scan_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .done        (done),
    .img_addr    (img_addr),
    .row_valid   (row_valid),
    .fill_zero   (fill_zero),
    .strip_start (strip_start),
    .strip_idx   (strip_idx),
    .blur_addr_r (blur_addr_r)
  );

  strip_window u_window (
    .clk         (clk),
    .rst_n       (rst_n),
    .img_dout    (img_dout),
    .row_valid   (row_valid),
    .fill_zero   (fill_zero),
    .strip_start (strip_start),
    .strip_idx   (strip_idx),
    .win_valid   (win_valid),
    .windows     (windows)
  );

  // lane 0 is the leftmost strip pixel
  for (genvar i = 0; i < `STRIP_PIXELS; i++) begin : g_lane
    blur_lane u_lane (
      .clk        (clk),
      .rst_n      (rst_n),
      .win_valid  (win_valid),
      .window     (windows[i]),
      .lane_valid (lane_valid[i]),
      .pixel      (lane_pixels[`STRIP_PIXELS-1-i])
    );
  end

  // all lanes run in lockstep
  strip_merge u_merge (
    .clk         (clk),
    .rst_n       (rst_n),
    .lane_valid  (&lane_valid),
    .lane_pixels (lane_pixels),
    .strip_idx   (strip_idx),
    .strip_start (strip_start),
    .blur_dout   (blur_dout),
    .blur_we     (blur_we),
    .blur_addr_w (blur_addr_w),
    .blur_din    (blur_din)
  );

endmodule

`default_nettype wire

// ==== src/strip_merge.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blur_macros.svh"

module strip_merge (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          lane_valid,
  input  wire blur_geom_pkg::strip_pixels_t  lane_pixels,
  input  wire blur_geom_pkg::strip_idx_t     strip_idx,
  input  wire logic                          strip_start,
  input  wire blur_geom_pkg::row_word_t      blur_dout,
  output logic                               blur_we,
  output blur_geom_pkg::row_addr_t           blur_addr_w,
  output blur_geom_pkg::row_word_t           blur_din
);

  localparam int SP = `STRIP_PIXELS;
  localparam int ROW_PIXELS = blur_geom_pkg::ROW_PIXELS;

  blur_geom_pkg::row_addr_t  wr_row;
  blur_geom_pkg::row_word_t  merged;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_row <= '0;
    end else if (strip_start) begin
      wr_row <= '0;
    end else if (lane_valid) begin
      wr_row <= wr_row + 1'b1;
    end
  end

  // earlier strips from read-back, this strip from the lanes, later strips zero
  always_comb begin
    int slot;
    merged = '0;
    for (int p = 0; p < ROW_PIXELS; p++) begin
      slot = p / SP;
      if (slot < int'(strip_idx)) begin
        merged[ROW_PIXELS-1-p] = blur_dout[ROW_PIXELS-1-p];
      end else if (slot == int'(strip_idx)) begin
        merged[ROW_PIXELS-1-p] = lane_pixels[SP-1-(p % SP)];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_we     <= 1'b0;
      blur_addr_w <= '0;
    end else begin
      blur_we <= lane_valid;
      if (lane_valid) begin
        blur_addr_w <= wr_row;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lane_valid) begin
      blur_din <= merged;
    end
  end

endmodule

`default_nettype wire

// ==== src/blur_lane.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blur_macros.svh"

module blur_lane (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     win_valid,
  input  wire blur_geom_pkg::window_t   window,
  output logic                          lane_valid,
  output blur_geom_pkg::pixel_t         pixel
);

  // 16 x 255 still fits in the pixel width plus the shift
  localparam int SUM_W = `PIXEL_W + `KERNEL_SHIFT;
  localparam int WEIGHT [3][3] = '{'{1, 2, 1}, '{2, 4, 2}, '{1, 2, 1}};

  logic [SUM_W-1:0] sum;

  always_comb begin
    sum = '0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        sum = sum + SUM_W'(int'(window[r][c]) * WEIGHT[r][c]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= win_valid;
    end
  end

  // divide by 16, low bits dropped
  always_ff @(posedge clk) begin
    pixel <= sum[SUM_W-1:`KERNEL_SHIFT];
  end

endmodule

`default_nettype wire

// ==== src/strip_window.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blur_macros.svh"

module strip_window (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire blur_geom_pkg::row_word_t    img_dout,
  input  wire logic                        row_valid,
  input  wire logic                        fill_zero,
  input  wire logic                        strip_start,
  input  wire blur_geom_pkg::strip_idx_t   strip_idx,
  output logic                             win_valid,
  output blur_geom_pkg::window_t           windows [`STRIP_PIXELS]
);

  localparam int SP = `STRIP_PIXELS;
  localparam int ROW_PIXELS = blur_geom_pkg::ROW_PIXELS;

  blur_geom_pkg::strip_row_t cur_row;
  blur_geom_pkg::strip_row_t last_row;
  blur_geom_pkg::strip_row_t older_row;
  logic                      have_prev;

  // strip slice plus one halo pixel per side, zero outside the image
  always_comb begin
    int p;
    cur_row = '0;
    for (int j = 0; j < SP + 2; j++) begin
      p = int'(strip_idx) * SP - 1 + j;
      if (!fill_zero && p >= 0 && p < ROW_PIXELS) begin
        cur_row[SP+1-j] = img_dout[ROW_PIXELS-1-p];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      have_prev <= 1'b0;
    end else if (strip_start) begin
      have_prev <= 1'b0;
    end else if (row_valid) begin
      have_prev <= 1'b1;
    end
  end

  // cleared rows give the zero top border of each strip
  always_ff @(posedge clk) begin
    if (strip_start) begin
      last_row  <= '0;
      older_row <= '0;
    end else if (row_valid) begin
      older_row <= last_row;
      last_row  <= cur_row;
    end
  end

  assign win_valid = row_valid && have_prev;

  // lane i is centred on strip pixel i, so column i+1 of the slice
  always_comb begin
    for (int i = 0; i < SP; i++) begin
      for (int c = 0; c < 3; c++) begin
        windows[i][0][c] = older_row[SP+1-i-c];
        windows[i][1][c] = last_row[SP+1-i-c];
        windows[i][2][c] = cur_row[SP+1-i-c];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/strip_scan_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blur_macros.svh"

module strip_scan_ctrl (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     start,
  output logic                          done,
  output blur_geom_pkg::row_addr_t      img_addr,
  output logic                          row_valid,
  output logic                          fill_zero,
  output logic                          strip_start,
  output blur_geom_pkg::strip_idx_t     strip_idx,
  output blur_geom_pkg::row_addr_t      blur_addr_r
);

  localparam int CNT_W = $clog2(blur_ctrl_pkg::STRIP_PERIOD);
  localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(blur_ctrl_pkg::STRIP_PERIOD - 1);
  localparam logic [CNT_W-1:0] FILL_CYCLE = CNT_W'(blur_ctrl_pkg::FILL_CYCLE);
  localparam blur_geom_pkg::strip_idx_t LAST_STRIP = blur_geom_pkg::strip_idx_t'(`STRIPS - 1);

  blur_ctrl_pkg::scan_state_t state;
  logic [CNT_W-1:0]           cycle_cnt;
  logic                       scanning;
  logic                       issue;

  assign scanning = (state == blur_ctrl_pkg::SCAN_RUN);

  // image rows first, then one zero-fill row
  assign issue = scanning && (cycle_cnt <= FILL_CYCLE);

  assign img_addr = (scanning && cycle_cnt < FILL_CYCLE) ?
                    blur_geom_pkg::row_addr_t'(cycle_cnt) : '0;

  // strip registers are cleared here, one cycle ahead of the first row
  assign strip_start = scanning && (cycle_cnt == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= blur_ctrl_pkg::SCAN_IDLE;
      cycle_cnt <= '0;
      strip_idx <= '0;
      done      <= 1'b0;
    end else begin
      case (state)
        blur_ctrl_pkg::SCAN_IDLE: begin
          if (start) begin
            state     <= blur_ctrl_pkg::SCAN_RUN;
            cycle_cnt <= '0;
            strip_idx <= '0;
            done      <= 1'b0;
          end
        end
        blur_ctrl_pkg::SCAN_RUN: begin
          if (cycle_cnt == LAST_CYCLE) begin
            cycle_cnt <= '0;
            if (strip_idx == LAST_STRIP) begin
              state <= blur_ctrl_pkg::SCAN_DONE;
              done  <= 1'b1;
            end else begin
              strip_idx <= strip_idx + 1'b1;
            end
          end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end
        end
        blur_ctrl_pkg::SCAN_DONE: begin
          state <= blur_ctrl_pkg::SCAN_IDLE;
        end
        default: begin
          state <= blur_ctrl_pkg::SCAN_IDLE;
        end
      endcase
    end
  end

  // strobes follow the one-cycle image memory latency
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_valid <= 1'b0;
      fill_zero <= 1'b0;
    end else begin
      row_valid <= issue;
      fill_zero <= scanning && (cycle_cnt == FILL_CYCLE);
    end
  end

  // read back the row whose lane result lands two cycles later
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_addr_r <= '0;
    end else if (scanning && cycle_cnt != '0 && cycle_cnt <= FILL_CYCLE) begin
      blur_addr_r <= blur_geom_pkg::row_addr_t'(cycle_cnt - 1'b1);
    end else begin
      blur_addr_r <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== src/blur_ctrl_pkg.sv ====
`default_nettype none
`include "blur_macros.svh"

package blur_ctrl_pkg;

  typedef enum logic [1:0] {
    SCAN_IDLE,
    SCAN_RUN,
    SCAN_DONE
  } scan_state_t;

  // in-strip cycle that issues the zero-fill row
  localparam int FILL_CYCLE = `IMG_ROWS;

  // rows, fill row, and the window/lane/write pipeline drain
  localparam int STRIP_PERIOD = `IMG_ROWS + 4;

endpackage

`default_nettype wire

// ==== src/blur_geom_pkg.sv ====
`default_nettype none
`include "blur_macros.svh"

package blur_geom_pkg;

  localparam int ROW_PIXELS = `STRIPS * `STRIP_PIXELS;

  typedef logic [`PIXEL_W-1:0] pixel_t;

  // leftmost pixel (strip 0) sits in the top element
  typedef pixel_t [ROW_PIXELS-1:0] row_word_t;

  // left halo in the top element, right halo in element 0
  typedef pixel_t [`STRIP_PIXELS+1:0] strip_row_t;

  // indexed [row][col], row 0 is the top row, col 0 the left column
  typedef pixel_t [2:0][2:0] window_t;

  // lane 0 result in the top element, same order as the row word
  typedef pixel_t [`STRIP_PIXELS-1:0] strip_pixels_t;

  typedef logic [$clog2(`IMG_ROWS+1)-1:0] row_addr_t;

  typedef logic [$clog2(`STRIPS)-1:0] strip_idx_t;

endpackage

`default_nettype wire

// ==== src/blur_macros.svh ====
`ifndef BLUR_MACROS_SVH
`define BLUR_MACROS_SVH

// image height in rows
`define IMG_ROWS 8

// vertical strips across one row word
`define STRIPS 4

// output pixels per strip
`define STRIP_PIXELS 4

// grayscale pixel width
`define PIXEL_W 8

// kernel weights sum to 16
`define KERNEL_SHIFT 4

`endif
